/* bench/tcp_tx_ctl_chk.sv */
`default_nettype none

// protocol checks on the top-level ports
module tcp_tx_ctl_chk (
  input logic clk,
  input logic reset,
  input logic send,
  input logic strm_val,
  input logic strm_sof,
  input logic strm_eof,
  input logic in_val,
  input logic cts
);

  timeunit 1ns;
  timeprecision 1ps;

  // one pulse per transfer
  send_single_cycle : assert property (@(posedge clk) disable iff (reset) send |=> !send)
    else $error("send stayed high for more than one cycle");

  sof_with_val : assert property (@(posedge clk) disable iff (reset) strm_sof |-> strm_val)
    else $error("strm_sof without strm_val");

  eof_with_val : assert property (@(posedge clk) disable iff (reset) strm_eof |-> strm_val)
    else $error("strm_eof without strm_val");

  // user side honours clear-to-send
  write_needs_cts : assert property (@(posedge clk) disable iff (reset) in_val |-> cts)
    else $error("in_val high while cts is low");

endmodule : tcp_tx_ctl_chk

bind tcp_tx_ctl tcp_tx_ctl_chk i_tcp_tx_ctl_chk (.*);

`default_nettype wire

/* bench/tcp_tx_ctl_tb.sv */
`default_nettype none

module tcp_tx_ctl_tb
  import tcp_seq_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int MAX_PLD = 16;
  localparam int LOG_N   = 64; // sends the engine model can record

  logic       clk  = 1'b0;
  logic       req  = 1'b0;    // driven by the engine model
  logic       sent = 1'b0;
  logic       reset, init, in_val, in_snd, flush;
  seq_t       init_seq, rem_ack;
  logic [7:0] in_dat;
  logic       cts, send, strm_val, strm_sof, strm_eof, force_dcn, flushed;
  seq_t       loc_seq, pld_seq;
  len_t       pld_len;
  cks_t       pld_cks;
  logic [7:0] strm_dat;

  logic [15:0] lfsr = 16'd88;
  int          errors = 0;
  int          timeouts = 0;
  seq_t        wr_seq, exp_next; // next byte written and next packet start

  // scoreboard with one entry per expected packet
  seq_t       exp_seq [$];
  int         exp_len [$];
  cks_t       exp_cks [$];
  logic [7:0] exp_dat [$];  // payloads back to back
  logic [7:0] pend_dat [$]; // written but not yet cut into packets

  // what the engine model saw on each send
  seq_t       log_seq [0:LOG_N-1];
  len_t       log_len [0:LOG_N-1];
  cks_t       log_cks [0:LOG_N-1];
  logic [7:0] log_dat [0:LOG_N-1][0:MAX_PLD-1];
  int         log_cnt [0:LOG_N-1];
  int         log_sof [0:LOG_N-1]; // byte index that carried sof
  int         log_eof [0:LOG_N-1];
  int         n_sends = 0;
  int         n_done = 0;          // streams that reached eof

  tcp_tx_ctl #(
    .BUF_AW     (6),
    .PKT_AW     (2),
    .MAX_PLD    (MAX_PLD),
    .WAIT_TICKS (8),
    .RETX_VISITS(20),
    .RETX_TRIES (2)
  ) i_tcp_tx_ctl (.*);

  always #20 clk = ~clk; // 40 ns period

  ////////////////////////////////////////////////////////////
  // transmit engine model
  ////////////////////////////////////////////////////////////

  // req from send until eof and then one sent pulse
  always @(negedge clk) begin : engine
    int cur;
    cur  = n_sends - 1;
    sent <= 1'b0;
    if (send && n_sends < LOG_N) begin
      req              <= 1'b1;
      log_seq[n_sends] <= pld_seq;
      log_len[n_sends] <= pld_len;
      log_cks[n_sends] <= pld_cks;
      log_cnt[n_sends] <= 0;
      log_sof[n_sends] <= -1;
      log_eof[n_sends] <= -1;
      n_sends          <= n_sends + 1;
    end
    if (strm_val && cur >= 0 && log_cnt[cur] < MAX_PLD) begin
      log_dat[cur][log_cnt[cur]] <= strm_dat;
      if (strm_sof) log_sof[cur] <= log_cnt[cur];
      if (strm_eof) log_eof[cur] <= log_cnt[cur];
      log_cnt[cur] <= log_cnt[cur] + 1;
    end
    if (strm_val && strm_eof) begin
      req    <= 1'b0;
      sent   <= 1'b1;
      n_done <= n_done + 1;
    end
  end

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  // taps 16 14 13 11
  function automatic logic next_lfsr_bit();
    logic fb;
    fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
    lfsr = {lfsr[14:0], fb};
    return fb;
  endfunction

  function automatic logic [7:0] random_byte();
    logic [7:0] b;
    b = '0;
    for (int i = 0; i < 8; i++) b = {b[6:0], next_lfsr_bit()};
    return b;
  endfunction

  task automatic mismatch(input string name, input string what,
                          input logic [31:0] exp, input logic [31:0] act);
    errors++;
    $display("[ERROR] %s: %s expected 0x%0h actual 0x%0h", name, what, exp, act);
  endtask

  task automatic timed_out(input string name, input string what);
    timeouts++;
    $display("%s: gave up waiting for %s", name, what);
  endtask

  task automatic idle(input int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic wait_cts(input string name, input logic level);
    int t;
    t = 0;
    while (cts !== level && t < 500) begin
      @(negedge clk);
      t++;
    end
    if (cts !== level) timed_out(name, level ? "cts to rise" : "cts to fall");
  endtask

  task automatic wait_done(input string name, input int n);
    int t;
    t = 0;
    while (n_done < n && t < 3000) begin
      @(negedge clk);
      t++;
    end
    if (n_done < n) timed_out(name, "the end of a payload stream");
  endtask

  task automatic wait_dcn(input string name);
    int t;
    t = 0;
    while (force_dcn !== 1'b1 && t < 5000) begin
      @(negedge clk);
      t++;
    end
    if (force_dcn !== 1'b1) timed_out(name, "force_dcn");
  endtask

  task automatic wait_flushed(input string name);
    int t;
    t = 0;
    while (flushed !== 1'b1 && t < 200) begin
      @(negedge clk);
      t++;
    end
    if (flushed !== 1'b1) timed_out(name, "the flushed pulse");
  endtask

  task automatic open_connection(input string name, input seq_t seq);
    init     = 1'b1;
    init_seq = seq;
    rem_ack  = seq; // nothing acked yet
    @(negedge clk);
    init     = 1'b0;
    wr_seq   = seq;
    exp_next = seq;
    if (cts !== 1'b1) mismatch(name, "cts after init", 1, cts);
  endtask

  // bytes back to back while cts allows
  task automatic write_bytes(input string name, input int n);
    logic [7:0] b;
    for (int i = 0; i < n; i++) begin
      wait_cts(name, 1'b1);
      b      = random_byte();
      in_val = 1'b1;
      in_dat = b;
      pend_dat.push_back(b);
      wr_seq++;
      @(negedge clk);
      in_val = 1'b0;
    end
  endtask

  task automatic pulse_snd();
    in_snd = 1'b1;
    @(negedge clk);
    in_snd = 1'b0;
  endtask

  // next len written bytes form one packet with a word sum of big-endian pairs
  task automatic cut_packet(input int len);
    logic [7:0] b;
    cks_t       sum;
    sum = '0;
    for (int i = 0; i < len; i++) begin
      b = pend_dat.pop_front();
      exp_dat.push_back(b);
      sum += (i % 2 == 0) ? {16'h0, b, 8'h00} : {24'h0, b}; // odd tail padded low
    end
    exp_seq.push_back(exp_next);
    exp_len.push_back(len);
    exp_cks.push_back(sum);
    exp_next += len;
  endtask

  // logged send idx against the oldest expected packet
  task automatic compare_send(input string name, input int idx, input bit pop);
    int len;
    int i;
    len = exp_len[0];
    if (log_seq[idx] !== exp_seq[0]) mismatch(name, "pld_seq", exp_seq[0], log_seq[idx]);
    if (log_len[idx] !== len) mismatch(name, "pld_len", len, log_len[idx]);
    if (log_cks[idx] !== exp_cks[0]) mismatch(name, "pld_cks", exp_cks[0], log_cks[idx]);
    if (log_cnt[idx] !== len) mismatch(name, "stream bytes", len, log_cnt[idx]);
    if (log_sof[idx] !== 0) mismatch(name, "sof byte", 0, log_sof[idx]);
    if (log_eof[idx] !== len - 1) mismatch(name, "eof byte", len - 1, log_eof[idx]);
    for (i = 0; i < len && i < MAX_PLD; i++) begin
      if (log_dat[idx][i] !== exp_dat[i]) mismatch(name, "stream byte", exp_dat[i],
                                                   log_dat[idx][i]);
    end
    if (pop) begin
      repeat (len) void'(exp_dat.pop_front());
      void'(exp_seq.pop_front());
      void'(exp_len.pop_front());
      void'(exp_cks.pop_front());
    end
  endtask

  ////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////

  task automatic send_one_packet();
    int base;
    base = n_sends;
    open_connection("single", 32'hffff_fff0); // the stream crosses the seq wrap
    write_bytes("single", 5);
    pulse_snd();
    cut_packet(5);
    wait_done("single", base + 1);
    compare_send("single", base, 1'b1);
    rem_ack = exp_next;
  endtask

  task automatic cut_long_stream();
    int base;
    base = n_sends;
    write_bytes("back_to_back", 35);
    if (loc_seq !== wr_seq) mismatch("back_to_back", "loc_seq", wr_seq, loc_seq);
    cut_packet(16); // two full packets
    cut_packet(16);
    cut_packet(3);  // closed by the idle timeout
    wait_done("back_to_back", base + 3);
    for (int i = 0; i < 3; i++) compare_send("back_to_back", base + i, 1'b1);
    rem_ack = exp_next;
  endtask

  task automatic stay_quiet();
    int base;
    base = n_sends;
    idle(2000);
    if (n_sends != base) mismatch("quiet", "send count", base, n_sends);
  endtask

  // first send plus two retries and then the disconnect
  task automatic retry_until_disconnect();
    int base;
    base = n_sends;
    write_bytes("retry", 7);
    pulse_snd();
    cut_packet(7);
    wait_dcn("retry");
    if (n_done - base != 3) mismatch("retry", "sends before force_dcn", 3, n_done - base);
    compare_send("retry", base, 1'b0);
    compare_send("retry", base + 1, 1'b0);
    compare_send("retry", base + 2, 1'b1);
  endtask

  task automatic flush_open_packets();
    int base;
    open_connection("flush", 32'h0000_4321);
    base = n_sends;
    write_bytes("flush", 4);
    pulse_snd();
    cut_packet(4);
    write_bytes("flush", 6);
    pulse_snd();
    cut_packet(6);
    wait_done("flush", base + 2);
    compare_send("flush", base, 1'b1);
    compare_send("flush", base + 1, 1'b1);
    flush = 1'b1; // both still unacked
    wait_flushed("flush");
    base = n_sends;
    idle(2000);
    if (n_sends != base) mismatch("flush", "send count after flush", base, n_sends);
    flush = 1'b0;
  endtask

  task automatic fill_descriptor_table();
    int base;
    int k;
    open_connection("table_full", 32'h7fff_fffa); // crosses the sign bit
    base = n_sends;
    for (k = 0; k < 4; k++) begin
      write_bytes("table_full", 3);
      pulse_snd();
      cut_packet(3);
    end
    wait_cts("table_full", 1'b0);
    wait_done("table_full", base + 4);
    if (cts !== 1'b0) mismatch("table_full", "cts with four held", 0, cts);
    for (k = 0; k < 4; k++) compare_send("table_full", base + k, 1'b1);
    rem_ack = exp_next;
    wait_cts("table_full", 1'b1);
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    reset    = 1'b1;
    init     = 1'b0;
    init_seq = '0;
    rem_ack  = '0;
    in_val   = 1'b0;
    in_dat   = '0;
    in_snd   = 1'b0;
    flush    = 1'b0;
    repeat (5) @(negedge clk);
    reset = 1'b0;
    if ({cts, send, strm_val, strm_sof, strm_eof, force_dcn, flushed} !== 7'b0) begin
      mismatch("reset", "outputs after reset", 0,
               {cts, send, strm_val, strm_sof, strm_eof, force_dcn, flushed});
    end
    send_one_packet();
    cut_long_stream();
    stay_quiet();
    retry_until_disconnect();
    flush_open_packets();
    fill_descriptor_table();
    $display("run complete: %0d mismatches, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule : tcp_tx_ctl_tb

`default_nettype wire

/* logic/tcp_seq_pkg.sv */
`default_nettype none

////////////////////////////////////////////////////////////
// sequence space and payload types
////////////////////////////////////////////////////////////

package tcp_seq_pkg;

  // tcp sequence or acknowledge number, compared in wrapping order
  typedef logic [31:0] seq_t;

  // payload length in bytes
  typedef logic [15:0] len_t;

  // checksum accumulator, word sum kept unfolded
  // the 16-bit fold belongs to the header builder
  typedef logic [31:0] cks_t;

endpackage : tcp_seq_pkg

`default_nettype wire

/* logic/tcp_tx_buf.sv */
`default_nettype none

module tcp_tx_buf
  import tcp_seq_pkg::*;
#(
  parameter int BUF_AW = 6
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              init,
  input  seq_t              init_seq,
  input  logic              in_val,
  input  logic [7:0]        in_dat,
  input  seq_t              loc_ack,
  input  logic [BUF_AW-1:0] rd_addr,
  output logic [7:0]        rd_dat,
  output seq_t              loc_seq,
  output logic              buf_full
);

  localparam int unsigned DEPTH = 2 ** BUF_AW;

  logic [7:0] mem [0:DEPTH-1]; // one byte per sequence number
  seq_t       gap;             // bytes written but not yet acked

  ////////////////////////////////////////////////////////////
  // local sequence counter
  ////////////////////////////////////////////////////////////

  // counts the byte of this cycle, visible in the next one
  always_ff @(posedge clk) begin
    if (reset) begin
      loc_seq <= '0;
    end else if (init) begin
      loc_seq <= init_seq; // connection start
    end else if (in_val) begin
      loc_seq <= loc_seq + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // byte store
  ////////////////////////////////////////////////////////////

  // write side follows the stream, address is seq modulo depth
  always_ff @(posedge clk) begin
    if (in_val) begin
      mem[loc_seq[BUF_AW-1:0]] <= in_dat;
    end
  end

  // read side for the scanner, one cycle latency
  always_ff @(posedge clk) begin
    rd_dat <= mem[rd_addr];
  end

  // unacked bytes fill the store
  // the oldest one is overwritten if the stream keeps going
  assign gap      = loc_seq - loc_ack; // wraps with the sequence space
  assign buf_full = (gap >= seq_t'(DEPTH));

endmodule : tcp_tx_buf

`default_nettype wire

/* logic/tcp_tx_ctl.sv */
`default_nettype none

module tcp_tx_ctl
  import tcp_seq_pkg::*;
#(
  parameter int BUF_AW      = 6,  // byte buffer depth, log2
  parameter int PKT_AW      = 2,  // descriptor table depth, log2
  parameter int MAX_PLD     = 16,
  parameter int WAIT_TICKS  = 8,
  parameter int RETX_VISITS = 20,
  parameter int RETX_TRIES  = 2
) (
  input  logic       clk,
  input  logic       reset,
  input  logic       init,
  input  seq_t       init_seq,
  input  seq_t       rem_ack,
  input  logic       in_val,
  input  logic [7:0] in_dat,
  input  logic       in_snd,
  input  logic       flush,
  input  logic       req,
  input  logic       sent,
  output logic       cts,
  output seq_t       loc_seq,
  output logic       send,
  output seq_t       pld_seq,
  output len_t       pld_len,
  output cks_t       pld_cks,
  output logic       strm_val,
  output logic       strm_sof,
  output logic       strm_eof,
  output logic [7:0] strm_dat,
  output logic       force_dcn,
  output logic       flushed
);

  logic              buf_full, tbl_full, active, desc_wr;
  seq_t              desc_start, loc_ack;
  len_t              desc_len;
  cks_t              desc_cks;
  logic [BUF_AW-1:0] rd_addr;
  logic [7:0]        rd_dat;

  tcp_tx_buf #(.BUF_AW(BUF_AW)) i_tcp_tx_buf (
    .clk, .reset, .init, .init_seq, .in_val, .in_dat,
    .loc_ack, .rd_addr, .rd_dat, .loc_seq, .buf_full
  );

  // cuts the same stream that the buffer stores
  tcp_tx_packetizer #(
    .MAX_PLD   (MAX_PLD),
    .WAIT_TICKS(WAIT_TICKS)
  ) i_tcp_tx_packetizer (
    .clk, .reset, .in_val, .in_dat, .in_snd, .flush, .loc_seq, .buf_full,
    .tbl_full, .active, .cts, .desc_wr, .desc_start, .desc_len, .desc_cks
  );

  tcp_tx_scanner #(
    .BUF_AW     (BUF_AW),
    .PKT_AW     (PKT_AW),
    .RETX_VISITS(RETX_VISITS),
    .RETX_TRIES (RETX_TRIES)
  ) i_tcp_tx_scanner (
    .clk, .reset, .init, .init_seq, .rem_ack, .flush, .req, .sent,
    .desc_wr, .desc_start, .desc_len, .desc_cks, .rd_dat,
    .active, .tbl_full, .loc_ack, .rd_addr, .send, .pld_seq, .pld_len, .pld_cks,
    .strm_val, .strm_sof, .strm_eof, .strm_dat, .force_dcn, .flushed
  );

endmodule : tcp_tx_ctl

`default_nettype wire

/* logic/tcp_tx_packetizer.sv */
`default_nettype none

module tcp_tx_packetizer
  import tcp_seq_pkg::*, tcp_tx_pkg::*;
#(
  parameter int MAX_PLD    = 16,
  parameter int WAIT_TICKS = 8
) (
  input  logic       clk,
  input  logic       reset,
  input  logic       in_val,
  input  logic [7:0] in_dat,
  input  logic       in_snd,
  input  logic       flush,
  input  seq_t       loc_seq,
  input  logic       buf_full,
  input  logic       tbl_full,
  input  logic       active,
  output logic       cts,
  output logic       desc_wr,
  output seq_t       desc_start,
  output len_t       desc_len,
  output cks_t       desc_cks
);

  localparam int TW = $clog2(WAIT_TICKS + 1);

  pktz_state_t   state;
  len_t          cnt, cnt_nxt;         // bytes in the open packet
  cks_t          cks, cks_nxt, cks_fin;
  seq_t          start, start_nxt;     // seq of the first byte
  logic [7:0]    hold, last;           // high byte of an unpaired word
  logic [TW-1:0] idle_cnt;             // cycles since the last byte
  logic          pkt_open, close;

  // user may write only with a live connection and room everywhere
  assign cts = active && !tbl_full && !buf_full;

  ////////////////////////////////////////////////////////////
  // next values, including the byte of this cycle
  ////////////////////////////////////////////////////////////

  assign pkt_open  = (state == pktz_pend) || in_val;
  assign cnt_nxt   = cnt + len_t'(in_val);
  assign start_nxt = (state == pktz_idle) ? loc_seq : start;
  assign last      = in_val ? in_dat : hold;

  // odd count so far means this byte completes a big-endian word
  assign cks_nxt = (in_val && cnt[0]) ? cks + cks_t'({hold, in_dat}) : cks;
  // odd length pads the last byte with a low zero
  assign cks_fin = cnt_nxt[0] ? cks_nxt + cks_t'({last, 8'h00}) : cks_nxt;

  // the four ways a packet ends
  assign close = pkt_open && (in_snd ||
                              buf_full ||
                              (cnt_nxt == len_t'(MAX_PLD)) ||
                              (!in_val && idle_cnt == TW'(WAIT_TICKS - 1)));

  ////////////////////////////////////////////////////////////
  // packet fsm
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= pktz_idle;
      cnt      <= '0;
      cks      <= '0;
      idle_cnt <= '0;
      desc_wr  <= 1'b0;
    end else begin
      desc_wr <= close && !flush; // nothing new is queued while closing down
      if (close) begin
        state    <= pktz_idle;
        cnt      <= '0;
        cks      <= '0;
        idle_cnt <= '0;
      end else if (pkt_open) begin
        state    <= pktz_pend;
        cnt      <= cnt_nxt;
        cks      <= cks_nxt;
        idle_cnt <= in_val ? '0 : idle_cnt + 1'b1; // restart on every byte
      end
    end
  end

  // byte pairing, packet start and the descriptor itself
  always_ff @(posedge clk) begin
    if (in_val) hold <= in_dat;
    if (state == pktz_idle) start <= loc_seq; // seq of the coming first byte
    if (close) begin
      desc_start <= start_nxt;
      desc_len   <= cnt_nxt;
      desc_cks   <= cks_fin;
    end
  end

endmodule : tcp_tx_packetizer

`default_nettype wire

/* logic/tcp_tx_pkg.sv */
`default_nettype none

////////////////////////////////////////////////////////////
// transmit control state machines and opcodes
////////////////////////////////////////////////////////////

package tcp_tx_pkg;

  // packetizer: waiting for a first byte, or collecting a packet
  typedef enum logic {
    pktz_idle,
    pktz_pend
  } pktz_state_t;

  typedef enum logic [2:0] {
    scan_idle,   // no connection
    scan_scan,   // look for a present entry
    scan_choose, // pick a verdict
    scan_check,  // table update write
    scan_next,   // pop and ack bookkeeping
    scan_settle, // lets a delayed descriptor write land
    scan_stream, // payload readout to the tx engine
    scan_flush   // clear the table on closure
  } scan_state_t;

  // what a visit does to its entry
  typedef enum logic [1:0] {
    verdict_keep,
    verdict_free,
    verdict_resend
  } scan_verdict_t;

endpackage : tcp_tx_pkg

`default_nettype wire

/* logic/tcp_tx_scanner.sv */
`default_nettype none

module tcp_tx_scanner
  import tcp_seq_pkg::*, tcp_tx_pkg::*;
#(
  parameter int BUF_AW      = 6,
  parameter int PKT_AW      = 2,
  parameter int RETX_VISITS = 20,
  parameter int RETX_TRIES  = 2
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              init,
  input  seq_t              init_seq,
  input  seq_t              rem_ack,
  input  logic              flush,
  input  logic              req,
  input  logic              sent,
  input  logic              desc_wr,
  input  seq_t              desc_start,
  input  len_t              desc_len,
  input  cks_t              desc_cks,
  input  logic [7:0]        rd_dat,
  output logic              active,
  output logic              tbl_full,
  output seq_t              loc_ack,
  output logic [BUF_AW-1:0] rd_addr,
  output logic              send,
  output seq_t              pld_seq,
  output len_t              pld_len,
  output cks_t              pld_cks,
  output logic              strm_val,
  output logic              strm_sof,
  output logic              strm_eof,
  output logic [7:0]        strm_dat,
  output logic              force_dcn,
  output logic              flushed
);

  localparam int DEPTH = 2 ** PKT_AW;
  localparam int VW    = $clog2(RETX_VISITS + 1);
  localparam int TW    = $clog2(RETX_TRIES + 2); // room for one try past the limit

  // descriptor table
  seq_t              tbl_start  [0:DEPTH-1];
  len_t              tbl_len    [0:DEPTH-1];
  cks_t              tbl_cks    [0:DEPTH-1];
  logic [TW-1:0]     tbl_tries  [0:DEPTH-1];
  logic [VW-1:0]     tbl_visits [0:DEPTH-1];
  logic [DEPTH-1:0]  present;
  logic [PKT_AW:0]   push_ptr, pop_ptr, fill;
  logic [PKT_AW+1:0] held;

  scan_state_t       state;
  scan_verdict_t     verdict;
  logic [PKT_AW-1:0] idx; // entry being visited

  logic pend_v; // descriptor held back from the write port
  seq_t pend_start;
  len_t pend_len;
  cks_t pend_cks;

  logic [TW-1:0] cur_tries;
  logic [VW-1:0] cur_visits;
  seq_t          stop_rd, cur_stop, ack_diff, ack_adv;
  logic          give_up;

  // single write port shared by updates and new descriptors
  logic              upd_wr, new_wr, wr_en, wr_present;
  logic [PKT_AW-1:0] wr_idx;
  logic [TW-1:0]     wr_tries;
  logic [VW-1:0]     wr_visits;

  len_t cnt;                       // bytes issued in this send
  logic done, iss_val, iss_sof, iss_eof;

  assign active   = (state != scan_idle);
  assign fill     = push_ptr - pop_ptr;
  // count descriptors still on their way too, the open packet never overflows
  assign held     = {1'b0, fill} + (PKT_AW+2)'(pend_v) + (PKT_AW+2)'(desc_wr);
  assign tbl_full = (held >= (PKT_AW+2)'(DEPTH));

  assign stop_rd = tbl_start[idx] + seq_t'(tbl_len[idx]); // expected ack
  assign ack_adv = cur_stop - loc_ack;
  assign give_up = (cur_tries > TW'(RETX_TRIES));

  ////////////////////////////////////////////////////////////
  // table write port
  ////////////////////////////////////////////////////////////

  assign upd_wr = (state == scan_check); // the visit has priority
  assign new_wr = pend_v && !upd_wr && (state != scan_flush);
  assign wr_en  = upd_wr || new_wr;
  assign wr_idx = upd_wr ? idx : push_ptr[PKT_AW-1:0];

  always_comb begin
    wr_present = 1'b1;
    wr_tries   = cur_tries;
    wr_visits  = cur_visits;
    if (!upd_wr) begin
      wr_tries  = '0;
      wr_visits = VW'(RETX_VISITS); // so the first visit sends at once
    end else begin
      case (verdict)
        verdict_free   : wr_present = 1'b0;
        verdict_resend : begin
          if (!give_up) begin
            wr_tries  = cur_tries + 1'b1;
            wr_visits = '0;
          end
        end
        default        : wr_visits = cur_visits + 1'b1;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (new_wr) begin
      tbl_start[wr_idx] <= pend_start;
      tbl_len[wr_idx]   <= pend_len;
      tbl_cks[wr_idx]   <= pend_cks;
    end
    if (wr_en) begin
      tbl_tries[wr_idx]  <= wr_tries;
      tbl_visits[wr_idx] <= wr_visits;
    end
    if (desc_wr) begin
      pend_start <= desc_start;
      pend_len   <= desc_len;
      pend_cks   <= desc_cks;
    end
    if (state == scan_scan && present[idx]) begin // latch the visited entry
      pld_seq    <= tbl_start[idx];
      pld_len    <= tbl_len[idx];
      pld_cks    <= tbl_cks[idx];
      cur_tries  <= tbl_tries[idx];
      cur_visits <= tbl_visits[idx];
      cur_stop   <= stop_rd;
      ack_diff   <= stop_rd - rem_ack; // bit 31 set means already acked
    end
    strm_dat <= rd_dat;
  end

  ////////////////////////////////////////////////////////////
  // scan fsm
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= scan_idle;
      verdict   <= verdict_keep;
      idx       <= '0;
      push_ptr  <= '0;
      pop_ptr   <= '0;
      present   <= '0;
      pend_v    <= 1'b0;
      loc_ack   <= '0;
      rd_addr   <= '0;
      send      <= 1'b0;
      force_dcn <= 1'b0;
      flushed   <= 1'b0;
      cnt       <= '0;
      done      <= 1'b0;
      iss_val   <= 1'b0;
      iss_sof   <= 1'b0;
      iss_eof   <= 1'b0;
    end else begin
      send    <= 1'b0;
      flushed <= 1'b0;
      iss_val <= 1'b0;
      pend_v  <= desc_wr || (pend_v && !new_wr);
      if (wr_en) present[wr_idx] <= wr_present;
      if (new_wr) push_ptr <= push_ptr + 1'b1;
      case (state)
        scan_idle   : idx <= '0; // parked until init
        scan_scan   : begin
          if (flush) begin
            idx   <= '0;
            state <= scan_flush;
          end else if (present[idx]) state <= scan_choose;
          else idx <= idx + 1'b1; // empty slot, try the next
        end
        scan_choose : begin
          if (ack_diff[31] || ack_diff == '0) verdict <= verdict_free;
          else if (cur_visits == VW'(RETX_VISITS)) verdict <= verdict_resend;
          else verdict <= verdict_keep;
          state <= scan_check;
        end
        scan_check  : begin
          if (verdict == verdict_resend && give_up) force_dcn <= 1'b1; // stays until init
          if (verdict == verdict_resend && !give_up) begin
            send    <= 1'b1;
            rd_addr <= pld_seq[BUF_AW-1:0];
            cnt     <= '0;
            done    <= 1'b0;
            state   <= scan_stream;
          end else begin
            state <= scan_next;
          end
        end
        scan_next   : begin
          if (verdict == verdict_free) begin
            pop_ptr <= pop_ptr + 1'b1;
            if (!ack_adv[31]) loc_ack <= cur_stop; // never moves backwards
          end
          idx   <= idx + 1'b1;
          state <= scan_settle;
        end
        scan_settle : state <= scan_scan;
        scan_stream : begin
          if (req && !done) begin // one byte per req cycle
            iss_val <= 1'b1;
            iss_sof <= (cnt == '0);
            iss_eof <= (cnt == pld_len - 1'b1);
            done    <= (cnt == pld_len - 1'b1);
            cnt     <= cnt + 1'b1;
            rd_addr <= rd_addr + 1'b1;
          end
          if (flush) begin
            idx   <= '0;
            state <= scan_flush;
          end else if (sent) begin
            idx   <= idx + 1'b1;
            state <= scan_settle;
          end
        end
        scan_flush  : begin
          present[idx] <= 1'b0;
          idx          <= idx + 1'b1;
          if (&idx) begin // last slot cleared
            pop_ptr <= push_ptr;
            pend_v  <= 1'b0;
            flushed <= 1'b1;
            state   <= scan_idle;
          end
        end
        default     : state <= scan_idle;
      endcase
      if (init) begin // new connection, the table starts empty
        state     <= scan_scan;
        idx       <= '0;
        push_ptr  <= '0;
        pop_ptr   <= '0;
        present   <= '0;
        pend_v    <= 1'b0;
        loc_ack   <= init_seq;
        force_dcn <= 1'b0;
      end
    end
  end

  // output stage, data arrives one cycle after its address
  always_ff @(posedge clk) begin
    if (reset) begin
      strm_val <= 1'b0;
      strm_sof <= 1'b0;
      strm_eof <= 1'b0;
    end else begin
      strm_val <= iss_val;
      strm_sof <= iss_val && iss_sof;
      strm_eof <= iss_val && iss_eof;
    end
  end

endmodule : tcp_tx_scanner

`default_nettype wire

/* tcp_tx_ctl.f */
logic/tcp_seq_pkg.sv
logic/tcp_tx_pkg.sv
logic/tcp_tx_buf.sv
logic/tcp_tx_packetizer.sv
logic/tcp_tx_scanner.sv
logic/tcp_tx_ctl.sv
bench/tcp_tx_ctl_chk.sv
bench/tcp_tx_ctl_tb.sv
